//--- Bender.yml
package:
  name: memory_subsystem

sources:
  # package first, then the ram, the controller and the top level
  - hdl/coherence_pkg.sv
  - hdl/ram_model.sv
  - hdl/memory_control.sv
  - hdl/memory_subsystem.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_memory_subsystem.sv

//--- hdl/coherence_pkg.sv
/*
  coherence types shared by the memory side of a dual-core system
  word type, cache and ram request/response bundles, state enums
*/

`default_nettype none

package coherence_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // number of caches on the bus, fixed
  localparam int CPUS = 2;

  // progress of the ram on the current request
  // ERROR is reserved, the model never reports it
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ram_state_t;

  // everything one cache drives toward the bus
  typedef struct packed {
    logic  iren;
    word_t iaddr;
    logic  dren;
    logic  dwen;
    word_t daddr;
    word_t dstore;
    logic  cctrans;
    logic  ccwrite;
  } cache_req_t;

  // everything the bus returns to one cache
  typedef struct packed {
    logic  iwait;
    word_t iload;
    logic  dwait;
    word_t dload;
    logic  ccwait;
    logic  ccinv;
    word_t ccsnoopaddr;
  } cache_resp_t;

  // single-ported ram request, ren and wen exclusive
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } ram_req_t;

  typedef struct packed {
    ram_state_t state;
    word_t      load;
  } ram_resp_t;

  // bus controller states
  typedef enum logic [3:0]
  {
    IDLE,
    INSTRUCTION,
    STORE_1,
    STORE_2,
    ARBITRATE,
    SNOOP,
    LOAD_1,
    LOAD_2,
    CACHE_1,
    CACHE_2
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/memory_control.sv
/*
  coherence and arbitration for two write-back caches under MSI
  picks one requester by a least-recently-served bit, runs two-word
  block transfers against a single-ported ram, snoops the peer,
  forwards dirty blocks cache to cache and invalidates on upgrade
*/

`timescale 1ns/1ps
`default_nettype none

module memory_control
  import coherence_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  cache_req_t  cache_req [CPUS],
  output cache_resp_t cache_resp [CPUS],
  output ram_req_t    ram_req,
  input  ram_resp_t   ram_resp
);
  ctrl_state_t state, next_state;
  // cache to serve first on a tie
  logic lru, next_lru;
  // requester and the cache being snooped
  logic req_cpu, next_req_cpu;
  logic snoop_cpu, next_snoop_cpu;

  logic [CPUS-1:0] iren_v, dren_v, dwen_v, cctrans_v;
  logic            ram_done;

  // favoured cache if it wants the bus, else the other one
  function automatic logic pick(input logic [CPUS-1:0] want, input logic first);
    pick = want[first] ? first : ~first;
  endfunction

  always_comb
  begin
    for (int i = 0; i < CPUS; i++)
    begin
      iren_v[i]    = cache_req[i].iren;
      dren_v[i]    = cache_req[i].dren;
      dwen_v[i]    = cache_req[i].dwen;
      cctrans_v[i] = cache_req[i].cctrans;
    end
  end

  assign ram_done = (ram_resp.state == ACCESS);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      lru       <= 1'b0;
      req_cpu   <= 1'b0;
      snoop_cpu <= 1'b1;
    end
    else
    begin
      state     <= next_state;
      lru       <= next_lru;
      req_cpu   <= next_req_cpu;
      snoop_cpu <= next_snoop_cpu;
    end
  end

  // next state and requester capture
  always_comb
  begin
    next_state     = state;
    next_req_cpu   = req_cpu;
    next_snoop_cpu = snoop_cpu;

    case (state)
      IDLE:
      begin
        // write-back first, then coherence or read, then fetch
        if (|dwen_v)
        begin
          next_state   = STORE_1;
          next_req_cpu = pick(dwen_v, lru);
        end
        else if (|(dren_v | cctrans_v))
        begin
          next_state   = ARBITRATE;
          next_req_cpu = pick(dren_v | cctrans_v, lru);
        end
        else if (|iren_v)
        begin
          next_state   = INSTRUCTION;
          next_req_cpu = pick(iren_v, lru);
        end
        next_snoop_cpu = ~next_req_cpu;
      end
      INSTRUCTION:
      begin
        if (ram_done)
        begin
          next_state = IDLE;
        end
      end
      STORE_1:
      begin
        if (ram_done)
        begin
          next_state = STORE_2;
        end
      end
      ARBITRATE:
      begin
        // no read means an upgrade, finished here
        next_state = cache_req[req_cpu].dren ? SNOOP : IDLE;
      end
      SNOOP:
      begin
        // peer transitions only when it holds the block
        next_state = cache_req[snoop_cpu].cctrans ? CACHE_1 : LOAD_1;
      end
      CACHE_1:
      begin
        if (ram_done)
        begin
          next_state = CACHE_2;
        end
      end
      LOAD_1:
      begin
        if (ram_done)
        begin
          next_state = LOAD_2;
        end
      end
      STORE_2, CACHE_2, LOAD_2:
      begin
        if (ram_done)
        begin
          next_state = IDLE;
        end
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // cache and ram outputs
  always_comb
  begin
    for (int i = 0; i < CPUS; i++)
    begin
      cache_resp[i].iwait       = 1'b1;
      cache_resp[i].iload       = '0;
      cache_resp[i].dwait       = 1'b1;
      cache_resp[i].dload       = '0;
      cache_resp[i].ccwait      = 1'b0;
      cache_resp[i].ccinv       = 1'b0;
      cache_resp[i].ccsnoopaddr = '0;
    end
    ram_req  = '0;
    next_lru = lru;

    case (state)
      INSTRUCTION:
      begin
        ram_req.ren = 1'b1;
        ram_req.addr = cache_req[req_cpu].iaddr;
        cache_resp[req_cpu].iload = ram_resp.load;
        if (ram_done)
        begin
          cache_resp[req_cpu].iwait = 1'b0;
          next_lru = ~req_cpu;
        end
      end
      STORE_1, STORE_2:
      begin
        ram_req.wen   = 1'b1;
        ram_req.addr  = cache_req[req_cpu].daddr;
        ram_req.store = cache_req[req_cpu].dstore;
        if (ram_done)
        begin
          cache_resp[req_cpu].dwait = 1'b0;
          if (state == STORE_2)
          begin
            next_lru = ~req_cpu;
          end
        end
      end
      ARBITRATE:
      begin
        cache_resp[snoop_cpu].ccsnoopaddr = cache_req[req_cpu].daddr;
        if (cache_req[req_cpu].dren)
        begin
          // park the peer in its snoop state
          cache_resp[snoop_cpu].ccwait = 1'b1;
        end
        else if (cache_req[req_cpu].cctrans)
        begin
          // S to M on a write hit, drop the peer's copy
          cache_resp[snoop_cpu].ccinv = 1'b1;
          cache_resp[req_cpu].dwait   = 1'b0;
          next_lru = ~req_cpu;
        end
      end
      SNOOP:
      begin
        cache_resp[snoop_cpu].ccwait      = 1'b1;
        cache_resp[snoop_cpu].ccsnoopaddr = cache_req[req_cpu].daddr;
      end
      CACHE_1, CACHE_2:
      begin
        cache_resp[snoop_cpu].ccwait      = 1'b1;
        cache_resp[snoop_cpu].ccsnoopaddr = cache_req[req_cpu].daddr;
        // dirty word goes to the requester and back to ram at once
        cache_resp[req_cpu].dload = cache_req[snoop_cpu].dstore;
        cache_resp[snoop_cpu].ccinv = cache_req[req_cpu].ccwrite;
        ram_req.wen   = 1'b1;
        ram_req.addr  = cache_req[req_cpu].daddr;
        ram_req.store = cache_req[snoop_cpu].dstore;
        if (ram_done)
        begin
          // both sides step to the next word together
          cache_resp[req_cpu].dwait   = 1'b0;
          cache_resp[snoop_cpu].dwait = 1'b0;
          if (state == CACHE_2)
          begin
            next_lru = ~req_cpu;
          end
        end
      end
      LOAD_1, LOAD_2:
      begin
        ram_req.ren  = 1'b1;
        ram_req.addr = cache_req[req_cpu].daddr;
        cache_resp[req_cpu].dload = ram_resp.load;
        if (ram_done)
        begin
          cache_resp[req_cpu].dwait = 1'b0;
          if (state == LOAD_2)
          begin
            next_lru = ~req_cpu;
          end
        end
      end
      default:
      begin
        next_lru = lru;
      end
    endcase
  end

  // both dwaits low only on a ram ACCESS during a cache-to-cache word
  a_dwait_pair: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(cache_resp[0].dwait || cache_resp[1].dwait)
      |-> (state inside {CACHE_1, CACHE_2}) && ram_done
  ) else $error("both dwait low outside a cache transfer");

  a_ccinv_one: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(cache_resp[0].ccinv && cache_resp[1].ccinv)
  ) else $error("invalidate sent to both caches");

  a_ram_rw: assert property (
    @(posedge CLK) disable iff (!nRST) !(ram_req.ren && ram_req.wen)
  ) else $error("ram read and write driven together");

endmodule

`default_nettype wire

//--- hdl/memory_subsystem.sv
/*
  shared memory side of the dual-core system
  bus controller in front of a single-ported ram model
*/

`timescale 1ns/1ps
`default_nettype none

module memory_subsystem
  import coherence_pkg::*;
#(
  // BUSY cycles before ACCESS
  parameter int unsigned RAM_LATENCY = 2,
  // depth in words
  parameter int unsigned RAM_WORDS   = 1024
)
(
  input  logic        CLK,
  input  logic        nRST,
  input  cache_req_t  cache_req [CPUS],
  output cache_resp_t cache_resp [CPUS]
);
  // controller to ram
  ram_req_t  ram_req;
  ram_resp_t ram_resp;

  memory_control u_memory_control
  (
    .CLK        (CLK),
    .nRST       (nRST),
    .cache_req  (cache_req),
    .cache_resp (cache_resp),
    .ram_req    (ram_req),
    .ram_resp   (ram_resp)
  );

  ram_model
  #(
    .RAM_LATENCY (RAM_LATENCY),
    .RAM_WORDS   (RAM_WORDS)
  )
  u_ram_model
  (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (ram_req),
    .resp (ram_resp)
  );

endmodule

`default_nettype wire

//--- hdl/ram_model.sv
/*
  behavioral word memory with a fixed access latency
  BUSY for RAM_LATENCY cycles, then ACCESS for one cycle
  a write commits on the ACCESS cycle
*/

`timescale 1ns/1ps
`default_nettype none

module ram_model
  import coherence_pkg::*;
#(
  parameter int unsigned RAM_LATENCY = 2,
  // power of two, addressed by word
  parameter int unsigned RAM_WORDS   = 1024
)
(
  input  logic      CLK,
  input  logic      nRST,
  input  ram_req_t  req,
  output ram_resp_t resp
);
  localparam int AW = $clog2(RAM_WORDS);
  localparam int CW = (RAM_LATENCY > 0) ? $clog2(RAM_LATENCY + 1) : 1;
  localparam logic [CW-1:0] LAST = CW'(RAM_LATENCY);

  word_t mem [RAM_WORDS];

  logic [CW-1:0] count, eff_count, next_count;
  logic          active, fresh, last_active, last_wen;
  word_t         last_addr;
  logic [AW-1:0] idx;

  assign active = req.ren || req.wen;
  // byte address in, drop the two low bits
  assign idx = req.addr[AW+1:2];

  // new address or new direction restarts the latency count
  assign fresh = !last_active || (req.addr != last_addr) || (req.wen != last_wen);
  assign eff_count = fresh ? '0 : count;

  always_comb
  begin
    resp.state = FREE;
    resp.load  = '0;
    if (active)
    begin
      resp.state = (eff_count == LAST) ? ACCESS : BUSY;
      if (req.ren && (eff_count == LAST))
      begin
        resp.load = mem[idx];
      end
    end
  end

  // wrap to zero after ACCESS so a held request starts over
  assign next_count = (!active || (eff_count == LAST)) ? '0 : eff_count + 1'b1;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      count       <= '0;
      last_active <= 1'b0;
      last_wen    <= 1'b0;
    end
    else
    begin
      count       <= next_count;
      last_active <= active;
      last_wen    <= req.wen;
    end
  end

  // previous request address
  always_ff @(posedge CLK)
  begin
    last_addr <= req.addr;
  end

  always_ff @(posedge CLK)
  begin
    if (req.wen && (eff_count == LAST))
    begin
      mem[idx] <= req.store;
    end
  end

  a_ren_wen_exclusive: assert property (
    @(posedge CLK) disable iff (!nRST) !(req.ren && req.wen)
  ) else $error("ram read and write requested together");

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
hdl/coherence_pkg.sv
hdl/ram_model.sv
hdl/memory_control.sv
hdl/memory_subsystem.sv
tests/tb_memory_subsystem.sv

//--- tests/tb_checks.svh
/*
  testbench helpers for the memory subsystem
  xorshift source, compare tasks, cache request tasks with timeouts
*/

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int TIMEOUT_CYCLES = 100;

// xorshift32, advances the shared seed
function automatic word_t next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

task automatic abort_run(input string why);
  $display("%s", why);
  $display("tests failed");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
  if (got !== exp)
    abort_run($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
endtask

// only the coherence fields are compared
task automatic check_resp_flags(input cache_resp_t got, input cache_resp_t exp,
                                input string what);
  if ((got.ccinv !== exp.ccinv) || (got.ccsnoopaddr !== exp.ccsnoopaddr))
    abort_run($sformatf("[ERROR] %0t: %s got ccinv %b addr %h, expected ccinv %b addr %h",
                        $time, what, got.ccinv, got.ccsnoopaddr, exp.ccinv,
                        exp.ccsnoopaddr));
endtask

// sample before the edge until the wait bit of cache c drops
task automatic wait_ready(input int c, input bit fetch, input bit watch_peer,
                          output cache_resp_t seen, output cache_resp_t peer_seen);
  int n;
  bit done;
  cache_resp_t exp;
  n = 0;
  done = 1'b0;
  while (!done)
  begin
    @(posedge CLK);
    seen = cache_resp[c];
    peer_seen = cache_resp[1 - c];
    // a parked peer must snoop the requester's address
    if (watch_peer && peer_seen.ccwait)
    begin
      parked_cycles++;
      exp = '0;
      exp.ccsnoopaddr = cache_req[c].daddr;
      check_resp_flags(peer_seen, exp, "snooped cache flags");
    end
    done = fetch ? !seen.iwait : !seen.dwait;
    n++;
    if (!done && (n >= TIMEOUT_CYCLES))
      abort_run($sformatf("%s of cache %0d never dropped", fetch ? "iwait" : "dwait", c));
  end
  served_log.push_back(c);
endtask

// two-word write-back, next word presented after each dwait low
task automatic store_block(input int c, input word_t base, input word_t d0, input word_t d1);
  cache_resp_t seen, peer;
  word_t data [2];
  data[0] = d0;
  data[1] = d1;
  for (int w = 0; w < 2; w++)
  begin
    @(negedge CLK);
    cache_req[c].dwen   = 1'b1;
    cache_req[c].daddr  = base + 4 * w;
    cache_req[c].dstore = data[w];
    wait_ready(c, 1'b0, 1'b0, seen, peer);
  end
  @(negedge CLK);
  cache_req[c].dwen = 1'b0;
  add_block(base, d0, d1);
  favour = 1 - c;
endtask

// two-word read, ccwrite marks a read for ownership
task automatic load_block(input int c, input word_t base, input bit wr, input bit watch_peer,
                          output word_t g0, output word_t g1);
  cache_resp_t seen, peer;
  parked_cycles = 0;
  for (int w = 0; w < 2; w++)
  begin
    @(negedge CLK);
    cache_req[c].dren    = 1'b1;
    cache_req[c].ccwrite = wr;
    cache_req[c].daddr   = base + 4 * w;
    wait_ready(c, 1'b0, watch_peer, seen, peer);
    if (w == 0)
      g0 = seen.dload;
    else
      g1 = seen.dload;
  end
  @(negedge CLK);
  cache_req[c].dren    = 1'b0;
  cache_req[c].ccwrite = 1'b0;
  if (watch_peer && (parked_cycles == 0))
    abort_run($sformatf("cache %0d was never parked to snoop the read", 1 - c));
  favour = 1 - c;
endtask

`endif

//--- tests/tb_memory_subsystem.sv
/*
  testbench for the memory subsystem
  plays both caches, keeps a word model of the ram and
  runs stores, reads, forwards, upgrades and fetches
*/

`timescale 1ns/1ps
`default_nettype none

module tb_memory_subsystem
  import coherence_pkg::*;
;
  logic        CLK;
  logic        nRST;
  cache_req_t  cache_req [CPUS];
  cache_resp_t cache_resp [CPUS];

  word_t rng_state;
  // expected ram contents, only written words are read back
  word_t model_mem [word_t];
  word_t written [$];
  // cache the controller should favour next
  int    favour;
  // caches in the order their words completed
  int    served_log [$];
  // cycles the peer sat parked during the last read
  int    parked_cycles;

  memory_subsystem
  #(
    .RAM_LATENCY (2),
    .RAM_WORDS   (1024)
  )
  u_memory_subsystem
  (
    .CLK        (CLK),
    .nRST       (nRST),
    .cache_req  (cache_req),
    .cache_resp (cache_resp)
  );

  always #50 CLK = ~CLK;

  task automatic add_block(input word_t base, input word_t d0, input word_t d1);
    if (!model_mem.exists(base))
      written.push_back(base);
    model_mem[base]     = d0;
    model_mem[base + 4] = d1;
  endtask

  `include "tb_checks.svh"

  function automatic bit coin();
    word_t v;
    v = next_random();
    return v[0];
  endfunction

  // aligned two-word block inside the 4 KiB ram
  function automatic word_t rand_block();
    word_t v;
    v = next_random();
    return {20'h0, v[8:0], 3'b000};
  endfunction

  function automatic word_t pick_written();
    word_t v;
    v = next_random();
    return written[v % written.size()];
  endfunction

  // one iren held over two words, each checked against the model
  task automatic fetch_block(input int c, input word_t base);
    cache_resp_t seen, peer;
    for (int w = 0; w < 2; w++)
    begin
      @(negedge CLK);
      cache_req[c].iren  = 1'b1;
      cache_req[c].iaddr = base + 4 * w;
      wait_ready(c, 1'b1, 1'b0, seen, peer);
      check_word(seen.iload, model_mem[base + 4 * w], "fetched word");
      favour = 1 - c;
    end
    @(negedge CLK);
    cache_req[c].iren = 1'b0;
  endtask

  // peer holding a dirty block answers the snoop
  task automatic snoop_respond(input int p, input word_t base, input word_t d0,
                               input word_t d1, input bit wr);
    cache_resp_t seen, peer, exp;
    word_t data [2];
    int n;
    data[0] = d0;
    data[1] = d1;
    n = 0;
    @(posedge CLK);
    while (!cache_resp[p].ccwait)
    begin
      n++;
      if (n >= TIMEOUT_CYCLES)
        abort_run($sformatf("ccwait of cache %0d never rose", p));
      @(posedge CLK);
    end
    for (int w = 0; w < 2; w++)
    begin
      @(negedge CLK);
      cache_req[p].cctrans = 1'b1;
      cache_req[p].dstore  = data[w];
      wait_ready(p, 1'b0, 1'b0, seen, peer);
      exp = '0;
      exp.ccinv = wr;
      exp.ccsnoopaddr = base + 4 * w;
      check_resp_flags(seen, exp, "forwarding cache flags");
    end
    @(negedge CLK);
    cache_req[p].cctrans = 1'b0;
  endtask

  // S to M upgrade, peer invalidated in the finishing cycle
  task automatic upgrade(input int c, input word_t addr);
    cache_resp_t seen, peer, exp;
    @(negedge CLK);
    cache_req[c].cctrans = 1'b1;
    cache_req[c].ccwrite = 1'b1;
    cache_req[c].daddr   = addr;
    wait_ready(c, 1'b0, 1'b0, seen, peer);
    exp = '0;
    exp.ccinv = 1'b1;
    exp.ccsnoopaddr = addr;
    check_resp_flags(peer, exp, "upgrade peer flags");
    @(negedge CLK);
    cache_req[c].cctrans = 1'b0;
    cache_req[c].ccwrite = 1'b0;
    favour = 1 - c;
  endtask

  initial
  begin
    word_t base, d0, d1, g0, g1, a0, a1;
    int r, first;
    bit wr;
    CLK = 1'b0;
    nRST = 1'b0;
    rng_state = 32'h6e8f_925f;
    favour = 0;
    for (int i = 0; i < CPUS; i++)
    begin
      cache_req[i] = '0;
    end
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // block store, read back from ram with a quiet peer
    repeat (8)
    begin
      base = rand_block();
      d0 = next_random();
      d1 = next_random();
      store_block(int'(coin()), base, d0, d1);
      load_block(int'(coin()), base, 1'b0, 1'b1, g0, g1);
      check_word(g0, model_mem[base], "ram read word 0");
      check_word(g1, model_mem[base + 4], "ram read word 1");
    end

    // dirty block forwarded cache to cache and written back
    repeat (6)
    begin
      base = rand_block();
      d0 = next_random();
      d1 = next_random();
      r = int'(coin());
      wr = coin();
      fork
        load_block(r, base, wr, 1'b0, g0, g1);
        snoop_respond(1 - r, base, d0, d1, wr);
      join
      check_word(g0, d0, "forwarded word 0");
      check_word(g1, d1, "forwarded word 1");
      add_block(base, d0, d1);
      load_block(int'(coin()), base, 1'b0, 1'b1, g0, g1);
      check_word(g0, model_mem[base], "written-back word 0");
      check_word(g1, model_mem[base + 4], "written-back word 1");
    end

    repeat (4) upgrade(int'(coin()), pick_written());

    // both caches fetch, service alternates
    a0 = pick_written();
    a1 = pick_written();
    first = favour;
    served_log.delete();
    fork
      fetch_block(0, a0);
      fetch_block(1, a1);
    join
    for (int i = 0; i < 4; i++)
      check_word(word_t'(served_log[i]), word_t'((i % 2 == 0) ? first : 1 - first),
                 "fetch service order");

    // write-back beats a fetch raised in the same cycle
    base = rand_block();
    d0 = next_random();
    d1 = next_random();
    a0 = pick_written();
    r = int'(coin());
    served_log.delete();
    fork
      store_block(r, base, d0, d1);
      fetch_block(1 - r, a0);
    join
    // both store words ahead of the first fetch word
    for (int i = 0; i < 4; i++)
      check_word(word_t'(served_log[i]), word_t'((i < 2) ? r : 1 - r),
                 "store before fetch order");

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
